// File: Bender.yml
package:
  name: game_core

sources:
  - files:
      - game_pkg.sv
      - button_router.sv
      - game_fsm.sv
      - score_keeper.sv
      - volume_control.sv
      - status_panel.sv
      - game_core.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - game_core_checker.sv
      - game_core_tb.sv

// File: button_router.sv
`timescale 1ns/10ps

module button_router import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_up,
    input  logic        btn_down,
    input  game_state_t state,
    output logic        menu_up,
    output logic        menu_down,
    output logic        vol_up,
    output logic        vol_down
);

    logic up_prev;
    logic down_prev;
    logic up_rise;
    logic down_rise;

    // rising edge against the level seen on the last edge
    assign up_rise   = btn_up & ~up_prev;
    assign down_rise = btn_down & ~down_prev;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            up_prev   <= 1'b0;
            down_prev <= 1'b0;
            menu_up   <= 1'b0;
            menu_down <= 1'b0;
            vol_up    <= 1'b0;
            vol_down  <= 1'b0;
        end else begin
            up_prev   <= btn_up;
            down_prev <= btn_down;

            // menu pair only in the menu, volume pair only while playing
            menu_up   <= (state == MENU_IDLE) && up_rise;
            menu_down <= (state == MENU_IDLE) && down_rise;
            vol_up    <= (state == GAME_RUNNING) && up_rise;
            vol_down  <= (state == GAME_RUNNING) && down_rise;
        end
    end

endmodule

// File: game_core.f
game_pkg.sv
button_router.sv
game_fsm.sv
score_keeper.sv
volume_control.sv
status_panel.sv
game_core.sv
tb_clock_gen.sv
game_core_checker.sv
game_core_tb.sv

// File: game_core.sv
`timescale 1ns/10ps

module game_core import game_pkg::*; #(
    parameter int unsigned BLINK_DIV = 25_000_000  // clocks per blink step
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_up,
    input  logic        btn_down,
    input  logic        confirm,
    input  logic        back,
    input  logic        restart,
    input  logic        pause_sw,
    input  logic        enemy_hit,
    input  logic        shooter_hit,
    output led_t        led,
    output bcd_digit_t  score_tens,
    output bcd_digit_t  score_ones,
    output game_state_t state
);

    logic    menu_up;
    logic    menu_down;
    logic    vol_up;
    logic    vol_down;
    score_t  score;
    volume_t volume;

    // ==============================
    // input side
    // ==============================
    button_router u_button_router (
        .clk       (clk),
        .rst       (rst),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .state     (state),
        .menu_up   (menu_up),
        .menu_down (menu_down),
        .vol_up    (vol_up),
        .vol_down  (vol_down)
    );

    game_fsm u_game_fsm (
        .clk       (clk),
        .rst       (rst),
        .confirm   (confirm),
        .back      (back),
        .restart   (restart),
        .pause_sw  (pause_sw),
        .menu_up   (menu_up),
        .menu_down (menu_down),
        .score     (score),
        .state     (state)
    );

    score_keeper u_score_keeper (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .enemy_hit   (enemy_hit),   // strobes from the combat engine
        .shooter_hit (shooter_hit),
        .score       (score)
    );

    volume_control u_volume_control (
        .clk      (clk),
        .rst      (rst),
        .vol_up   (vol_up),
        .vol_down (vol_down),
        .volume   (volume)
    );

    // ==============================
    // output side
    // ==============================
    status_panel #(
        .BLINK_DIV (BLINK_DIV)
    ) u_status_panel (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .volume     (volume),
        .score      (score),
        .led        (led),
        .score_tens (score_tens),
        .score_ones (score_ones)
    );

endmodule

// File: game_core_checker.sv
`timescale 1ns/10ps

module game_core_checker import game_pkg::*; #(
    parameter int unsigned MAX_CYCLES = 1000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_up,
    input  logic        btn_down,
    input  logic        confirm,
    input  logic        back,
    input  logic        restart,
    input  logic        pause_sw,
    input  logic        enemy_hit,
    input  logic        shooter_hit,
    input  led_t        led,
    input  bcd_digit_t  score_tens,
    input  bcd_digit_t  score_ones,
    input  game_state_t state,
    output logic        timed_out
);

    int unsigned cycles       = 0;
    int unsigned error_count  = 0;
    int unsigned test_errors  = 0;
    int unsigned test_count   = 0;
    int unsigned blink_pulses = 0;  // all-ones pulses seen in the win state

    // ==============================
    // cycle model
    // ==============================
    game_state_t m_state;
    game_state_t m_saved;
    game_state_t n_state;
    logic        m_cursor;
    logic        up_prev;
    logic        down_prev;
    logic        m_menu_up;
    logic        m_menu_down;
    logic        m_vol_up;
    logic        m_vol_down;
    int          m_score;
    int          m_shown;     // score behind the digit registers
    int          m_vol;
    led_t        m_led;
    led_t        m_led_next;
    led_t        led_last;
    logic        led_known;   // low while the blink owns the LEDs
    logic        next_known;

    task automatic report_value(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        $display("Fail %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        error_count++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d mismatches", test_count, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic expect_blinks(input int unsigned count);
        if (blink_pulses != count) report_value("blink_pulses", 16'(count), 16'(blink_pulses));
        if (led !== '0) report_value("led", 16'h0000, led);
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_state = MENU_IDLE;
            m_saved = MENU_IDLE;
            {m_cursor, up_prev, down_prev} = 3'b0;
            {m_menu_up, m_menu_down, m_vol_up, m_vol_down} = 4'b0;
            m_score    = 0;
            m_shown    = 0;
            m_vol      = VOL_DEFAULT;
            {m_led, m_led_next, led_last} = '0;
            {led_known, next_known} = 2'b11;
        end else begin
            if (state !== m_state) report_value("state", 16'(m_state), 16'(state));
            if (led_known && led !== m_led) report_value("led", m_led, led);
            if (score_tens !== m_shown / 10) begin
                report_value("score_tens", 16'(m_shown / 10), 16'(score_tens));
            end
            if (score_ones !== m_shown % 10) begin
                report_value("score_ones", 16'(m_shown % 10), 16'(score_ones));
            end
            if (m_state == GAME_WIN) begin
                if (!led_known && led !== 16'h0000 && led !== 16'hffff) begin
                    $display("Fail led 0x%h during the win blink, expected 0x0000 or 0xffff", led);
                    error_count++;
                    test_errors++;
                end
                if (led == 16'hffff && led_last != 16'hffff) blink_pulses++;
            end else begin
                blink_pulses = 0;
            end
            led_last = led;

            // LED pipeline, two registers deep
            m_led     = m_led_next;
            led_known = next_known;
            next_known = (m_state != GAME_WIN);
            if (m_state == GAME_RUNNING || m_state == GAME_PAUSE) m_led_next = (16'h1 << m_vol) - 1;
            else m_led_next = '0;

            // next state from the cursor as it stands before this edge
            n_state = m_state;
            case (m_state)
                MENU_IDLE:     if (confirm) n_state = m_cursor ? MENU_TUTORIAL : GAME_RUNNING;
                MENU_TUTORIAL: if (back) n_state = MENU_IDLE;
                GAME_RUNNING:  if (pause_sw) n_state = GAME_PAUSE;
                               else if (m_score >= WIN_SCORE) n_state = GAME_WIN;
                GAME_PAUSE:    if (!pause_sw) n_state = m_saved;
                GAME_WIN, GAME_OVER: if (restart) n_state = MENU_IDLE;
                default:       n_state = MENU_IDLE;
            endcase

            if (m_vol_up && m_vol < VOL_MAX) m_vol++;
            else if (m_vol_down && m_vol > VOL_MIN) m_vol--;
            if (m_state == MENU_IDLE && m_menu_up) m_cursor = 1'b0;
            else if (m_state == MENU_IDLE && m_menu_down) m_cursor = 1'b1;
            m_menu_up   = (m_state == MENU_IDLE) && btn_up && !up_prev;
            m_menu_down = (m_state == MENU_IDLE) && btn_down && !down_prev;
            m_vol_up    = (m_state == GAME_RUNNING) && btn_up && !up_prev;
            m_vol_down  = (m_state == GAME_RUNNING) && btn_down && !down_prev;
            up_prev     = btn_up;
            down_prev   = btn_down;

            if (m_state != GAME_PAUSE && n_state == GAME_PAUSE) m_saved = m_state;
            m_shown = m_score;
            if (m_state == GAME_RUNNING && m_score < SCORE_CAP) begin
                m_score += (enemy_hit ? ENEMY_POINTS : 0) + (shooter_hit ? SHOOTER_POINTS : 0);
            end else if (m_state == GAME_WIN) begin
                m_score = 0;
            end
            m_state = n_state;
        end
    end

    // ==============================
    // run limit
    // ==============================
    initial timed_out = 1'b0;

    always @(posedge clk) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            timed_out = 1'b1;
        end
    end

endmodule

// File: game_core_tb.sv
`timescale 1ns/10ps

module game_core_tb import game_pkg::*; ();

    localparam int unsigned BLINK_DIV    = 4;
    localparam int unsigned MENU_PRESSES = 12;
    localparam int unsigned VOL_PRESSES  = 16;
    localparam int unsigned PAUSE_HITS   = 8;

    // ==============================
    // cycle budget per test
    // ==============================
    localparam int unsigned RESET_LEN  = 8;
    localparam int unsigned MENU_LEN   = MENU_PRESSES * 4 + 40;
    localparam int unsigned VOL_LEN    = VOL_PRESSES * 4 + 8;
    localparam int unsigned PAUSE_LEN  = PAUSE_HITS + 16;
    localparam int unsigned SCORE_LEN  = 40;
    localparam int unsigned BLINK_LEN  = BLINK_DIV * (2 * BLINK_TIMES + 10) + 16;
    localparam int unsigned MAX_CYCLES =
        2 * (RESET_LEN + MENU_LEN + VOL_LEN + PAUSE_LEN + SCORE_LEN + BLINK_LEN);

    logic        clk;
    logic        rst;
    logic        btn_up;
    logic        btn_down;
    logic        confirm;
    logic        back;
    logic        restart;
    logic        pause_sw;
    logic        enemy_hit;
    logic        shooter_hit;
    led_t        led;
    bcd_digit_t  score_tens;
    bcd_digit_t  score_ones;
    game_state_t state;
    logic        timed_out;
    logic [15:0] lfsr_q;  // random source

    tb_clock_gen u_clock (.clk(clk), .rst(rst));

    game_core #(.BLINK_DIV(BLINK_DIV)) dut (
        .clk(clk), .rst(rst), .btn_up(btn_up), .btn_down(btn_down),
        .confirm(confirm), .back(back), .restart(restart), .pause_sw(pause_sw),
        .enemy_hit(enemy_hit), .shooter_hit(shooter_hit), .led(led),
        .score_tens(score_tens), .score_ones(score_ones), .state(state)
    );

    game_core_checker #(.MAX_CYCLES(MAX_CYCLES)) chk (
        .clk(clk), .rst(rst), .btn_up(btn_up), .btn_down(btn_down),
        .confirm(confirm), .back(back), .restart(restart), .pause_sw(pause_sw),
        .enemy_hit(enemy_hit), .shooter_hit(shooter_hit), .led(led),
        .score_tens(score_tens), .score_ones(score_ones), .state(state),
        .timed_out(timed_out)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic random_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    task press_button(input logic up);  // one cycle high, two low
        btn_up   = up;
        btn_down = !up;
        @(negedge clk);
        btn_up   = 1'b0;
        btn_down = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task wait_state(input game_state_t target);
        while (state !== target) @(negedge clk);
    endtask

    initial begin
        {btn_up, btn_down, confirm, back, restart} = 5'b0;
        {pause_sw, enemy_hit, shooter_hit} = 3'b0;
        lfsr_q = 16'd25993;
        wait (rst === 1'b0);
        repeat (4) @(negedge clk);
        chk.finish_test("reset");

        // ==============================
        // menu
        // ==============================
        press_button(1'b0);
        confirm = 1'b1;
        @(negedge clk);
        confirm = 1'b0;
        wait_state(MENU_TUTORIAL);
        back = 1'b1;
        @(negedge clk);
        back = 1'b0;
        wait_state(MENU_IDLE);
        for (int i = 0; i < MENU_PRESSES; i++) press_button(random_bit());
        confirm = 1'b1;
        @(negedge clk);
        confirm = 1'b0;
        while (state == MENU_IDLE) @(negedge clk);
        if (state == MENU_TUTORIAL) begin  // leave, move to start, confirm again
            back = 1'b1;
            @(negedge clk);
            back = 1'b0;
            wait_state(MENU_IDLE);
            press_button(1'b1);
            confirm = 1'b1;
            @(negedge clk);
            confirm = 1'b0;
        end
        wait_state(GAME_RUNNING);
        chk.finish_test("menu");

        for (int i = 0; i < VOL_PRESSES; i++) press_button(random_bit());
        repeat (2) @(negedge clk);
        chk.finish_test("volume");

        pause_sw = 1'b1;
        wait_state(GAME_PAUSE);
        for (int i = 0; i < PAUSE_HITS; i++) begin
            enemy_hit   = random_bit();
            shooter_hit = random_bit();
            @(negedge clk);
        end
        {enemy_hit, shooter_hit} = 2'b0;
        press_button(random_bit());  // routed nowhere while paused
        pause_sw = 1'b0;
        wait_state(GAME_RUNNING);
        chk.finish_test("pause");

        while (state !== GAME_WIN) begin
            enemy_hit   = random_bit();
            shooter_hit = random_bit();
            @(negedge clk);
        end
        {enemy_hit, shooter_hit} = 2'b0;
        while (score_tens != 0 || score_ones != 0) @(negedge clk);
        chk.finish_test("scoring and win");

        // ==============================
        // win blink, then back to the menu
        // ==============================
        while (!(chk.blink_pulses == BLINK_TIMES && led == '0)) @(negedge clk);
        repeat (8 * BLINK_DIV) @(negedge clk);
        chk.expect_blinks(BLINK_TIMES);
        restart = 1'b1;
        wait_state(MENU_IDLE);
        restart = 1'b0;
        repeat (4) @(negedge clk);
        chk.finish_test("win blink and restart");

        $display("tests %0d, mismatches %0d", chk.test_count, chk.error_count);
        if (chk.error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        wait (timed_out === 1'b1);
        $display("Errors found");
        $finish;
    end

endmodule

// File: game_fsm.sv
`timescale 1ns/10ps

module game_fsm import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        confirm,
    input  logic        back,
    input  logic        restart,
    input  logic        pause_sw,
    input  logic        menu_up,
    input  logic        menu_down,
    input  score_t      score,
    output game_state_t state
);

    game_state_t state_next;
    game_state_t saved_state;  // where pause returns to
    logic        cursor;       // 0 start, 1 tutorial

    // ==============================
    // next state
    // ==============================
    always_comb begin
        state_next = state;
        case (state)
            MENU_IDLE: begin
                if (confirm) begin
                    state_next = cursor ? MENU_TUTORIAL : GAME_RUNNING;
                end
            end
            MENU_TUTORIAL: begin
                if (back) state_next = MENU_IDLE;
            end
            GAME_RUNNING: begin
                if (pause_sw) begin
                    state_next = GAME_PAUSE;  // pause wins over the score test
                end else if (score >= WIN_SCORE) begin
                    state_next = GAME_WIN;
                end
            end
            GAME_PAUSE: begin
                if (!pause_sw) state_next = saved_state;
            end
            GAME_WIN, GAME_OVER: begin
                if (restart) state_next = MENU_IDLE;
            end
            default: state_next = MENU_IDLE;
        endcase
    end

    // ==============================
    // state registers
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= MENU_IDLE;
            saved_state <= MENU_IDLE;
        end else begin
            state <= state_next;
            if (state != GAME_PAUSE && state_next == GAME_PAUSE) begin
                saved_state <= state;
            end
        end
    end

    // menu cursor, two entries so it clamps by itself
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cursor <= 1'b0;
        end else if (state == MENU_IDLE) begin
            if (menu_up) begin
                cursor <= 1'b0;
            end else if (menu_down) begin
                cursor <= 1'b1;
            end
        end
    end

endmodule

// File: game_pkg.sv
package game_pkg;

    // ==============================
    // game states
    // ==============================
    typedef enum logic [2:0] {
        MENU_IDLE     = 3'd0,
        MENU_TUTORIAL = 3'd1,
        GAME_RUNNING  = 3'd2,
        GAME_OVER     = 3'd3,  // no health left in this core
        GAME_WIN      = 3'd4,
        GAME_PAUSE    = 3'd5
    } game_state_t;

    // ==============================
    // data words
    // ==============================
    typedef logic [7:0]  score_t;      // binary score
    typedef logic [3:0]  volume_t;     // volume level
    typedef logic [15:0] led_t;        // board LED word
    typedef logic [3:0]  bcd_digit_t;  // one decimal digit

    // ==============================
    // game constants
    // ==============================
    localparam score_t WIN_SCORE      = 8'd10;
    localparam score_t SCORE_CAP      = 8'd99;  // no additions from here on
    localparam score_t ENEMY_POINTS   = 8'd1;
    localparam score_t SHOOTER_POINTS = 8'd2;

    localparam volume_t VOL_MIN     = 4'd1;
    localparam volume_t VOL_MAX     = 4'd5;
    localparam volume_t VOL_DEFAULT = 4'd3;

    // off steps counted on a win
    localparam int unsigned BLINK_TIMES = 6;

endpackage

// File: score_keeper.sv
`timescale 1ns/10ps

module score_keeper import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    input  logic        enemy_hit,
    input  logic        shooter_hit,
    output score_t      score
);

    score_t enemy_add;
    score_t shooter_add;

    // points picked per strobe, both can land in one cycle
    assign enemy_add   = enemy_hit ? ENEMY_POINTS : '0;
    assign shooter_add = shooter_hit ? SHOOTER_POINTS : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            score <= '0;
        end else begin
            case (state)
                GAME_RUNNING: begin
                    if (score < SCORE_CAP) begin
                        score <= score + enemy_add + shooter_add;
                    end
                end
                GAME_WIN: begin
                    score <= '0;  // fresh round after a win
                end
                default: begin
                    score <= score;  // menu, pause, over
                end
            endcase
        end
    end

endmodule

// File: status_panel.sv
`timescale 1ns/10ps

module status_panel import game_pkg::*; #(
    parameter int unsigned BLINK_DIV = 25_000_000
) (
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    input  volume_t     volume,
    input  score_t      score,
    output led_t        led,
    output bcd_digit_t  score_tens,
    output bcd_digit_t  score_ones
);

    localparam int unsigned DIV_W = (BLINK_DIV > 1) ? $clog2(BLINK_DIV) : 1;
    localparam int unsigned CNT_W = $clog2(BLINK_TIMES + 1);
    localparam led_t        LED_ON  = 16'hffff;
    localparam led_t        LED_OFF = 16'h0000;

    logic [DIV_W-1:0] div_cnt;
    logic             step;         // one cycle per blink step
    logic             blink_state;  // 1 while the LEDs are lit
    logic [CNT_W-1:0] blink_count;  // off steps so far
    logic             blink_enable;
    led_t             led_next;
    led_t             vol_bar;

    assign step    = (div_cnt == DIV_W'(BLINK_DIV - 1));
    assign vol_bar = ~(LED_ON << volume);  // low volume bits set

    // ==============================
    // blink divider
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (state != GAME_WIN || step) begin
            div_cnt <= '0;  // restarts outside the win state
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==============================
    // next LED word
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blink_state  <= 1'b0;
            blink_count  <= '0;
            blink_enable <= 1'b0;
            led_next     <= LED_OFF;
        end else if (state == GAME_WIN) begin
            if (!blink_enable) begin
                led_next <= LED_OFF;
                if (step) begin  // first step only arms the blink
                    blink_enable <= 1'b1;
                    blink_state  <= 1'b0;
                    blink_count  <= '0;
                end
            end else if (step && blink_count < CNT_W'(BLINK_TIMES)) begin
                if (!blink_state) begin
                    led_next    <= LED_ON;
                    blink_state <= 1'b1;
                end else begin
                    led_next    <= LED_OFF;
                    blink_state <= 1'b0;
                    blink_count <= blink_count + 1'b1;
                end
            end
        end else if (state == GAME_RUNNING || state == GAME_PAUSE) begin
            led_next <= vol_bar;
        end else begin
            led_next     <= LED_OFF;
            blink_enable <= 1'b0;
        end
    end

    // output registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led        <= LED_OFF;
            score_tens <= '0;
            score_ones <= '0;
        end else begin
            led        <= led_next;
            score_tens <= bcd_digit_t'(score / 8'd10);
            score_ones <= bcd_digit_t'(score % 8'd10);
        end
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(negedge clk);  // covers two rising edges
        rst = 1'b0;
    end

endmodule

// File: volume_control.sv
`timescale 1ns/10ps

module volume_control import game_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    vol_up,
    input  logic    vol_down,
    output volume_t volume
);

    // ==============================
    // level between VOL_MIN and VOL_MAX
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            volume <= VOL_DEFAULT;
        end else if (vol_up && volume < VOL_MAX) begin
            volume <= volume + 4'd1;
        end else if (vol_down && volume > VOL_MIN) begin
            volume <= volume - 4'd1;
        end
    end

endmodule
